// File: glb_bank.sv
`timescale 1ns/1ps
`default_nettype none

module glb_bank import glb_param_pkg::*, glb_types_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         wr_en,
    input  glb_addr_t    wr_addr,
    input  bank_data_t   wr_data,
    input  rdrq_packet_t rdrq_packet,
    output rdrs_packet_t rdrs_packet
);

bank_data_t mem [BANK_DEPTH];
bank_data_t rd_data_pipe [BANK_RD_LATENCY];
logic [BANK_RD_LATENCY-1:0] rd_valid_pipe;

// rows are addressed by the byte address above the row offset
always_ff @(posedge clk) begin
    if (wr_en) begin
        mem[wr_addr[GLB_ADDR_WIDTH-1:BANK_ROW_LSB]] <= wr_data;
    end
    rd_data_pipe[0] <= mem[rdrq_packet.rd_addr[GLB_ADDR_WIDTH-1:BANK_ROW_LSB]];
    for (int i = 1; i < BANK_RD_LATENCY; i++) begin
        rd_data_pipe[i] <= rd_data_pipe[i-1];
    end
end

// valid travels alongside the data, several reads may overlap
always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        rd_valid_pipe <= '0;
    end else begin
        rd_valid_pipe <= {rd_valid_pipe[BANK_RD_LATENCY-2:0], rdrq_packet.rd_en};
    end
end

assign rdrs_packet.rd_data_valid = rd_valid_pipe[BANK_RD_LATENCY-1];
assign rdrs_packet.rd_data = rd_data_pipe[BANK_RD_LATENCY-1];

a_rd_latency: assert property (@(posedge clk) disable iff (reset)
    rdrq_packet.rd_en |-> ##BANK_RD_LATENCY rdrs_packet.rd_data_valid)
    else $error("bank response missing %0d cycles after read", BANK_RD_LATENCY);

endmodule

`default_nettype wire

// File: glb_core_load_dma.sv
`timescale 1ns/1ps
`default_nettype none

module glb_core_load_dma import glb_param_pkg::*, glb_types_pkg::*; (
    input  logic           clk,
    input  logic           clk_en,
    input  logic           reset,
    input  ld_dma_mode_e   cfg_ld_dma_mode,
    input  dma_ld_header_t cfg_ld_dma_header [QUEUE_DEPTH],
    input  logic           strm_start_pulse,
    output logic           invalidate_pulse [QUEUE_DEPTH],
    output rdrq_packet_t   rdrq_packet,
    input  rdrs_packet_t   rdrs_packet,
    output cgra_data_t     stream_data,
    output logic           stream_data_valid,
    output logic           stream_done_pulse
);

typedef enum logic [1:0] {STRM_STOP, STRM_ACTIVE, STRM_GAP} strm_state_e;

strm_state_e state, state_next;
dma_ld_header_t dma_header_int [QUEUE_DEPTH];
dma_ld_header_t run_hdr, cur_hdr;
logic dma_validate_d1 [QUEUE_DEPTH];
logic dma_active, strm_run, issue, carry, last_word;
logic start_pulse_internal, start_pulse_next, done_pulse_internal;
q_sel_t q_sel;
num_words_t active_cnt, active_cnt_next, inactive_cnt, inactive_cnt_next, active_left;
num_words_t itr [LOOP_LEVEL];
num_words_t itr_next [LOOP_LEVEL];
logic itr_last [LOOP_LEVEL];
glb_addr_t strm_addr, itr_ofs;
rdrq_packet_t strm_rdrq;
logic row_same;
bank_data_t rdrs_cache;
logic [BANK_ROW_LSB-CGRA_LANE_LSB-1:0] lane;
logic start_pulse_d [START_PULSE_SHIFT_DEPTH];
logic rd_en_d [FIXED_LATENCY];
glb_addr_t rd_addr_d [FIXED_LATENCY];
logic done_d [FIXED_LATENCY+1];

// latch a descriptor on the rising edge of its valid bit
always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            dma_validate_d1[i] <= 1'b0;
            dma_header_int[i] <= '0;
        end
    end else if (clk_en) begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            dma_validate_d1[i] <= cfg_ld_dma_header[i].valid;
            if (cfg_ld_dma_header[i].valid && !dma_validate_d1[i]) begin
                dma_header_int[i] <= cfg_ld_dma_header[i];
            end else if (invalidate_pulse[i]) begin
                dma_header_int[i].valid <= 1'b0;
            end
        end
    end
end

// consumed entry is released as its stream starts
always_comb begin
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
        invalidate_pulse[i] = start_pulse_internal && (q_sel == q_sel_t'(i))
                              && dma_header_int[i].valid;
    end
end

assign strm_run = (state != STRM_STOP);

always_comb begin
    case (cfg_ld_dma_mode)
        NORMAL: start_pulse_next = strm_start_pulse && !strm_run;
        REPEAT, AUTO_INCR: start_pulse_next = !strm_run && ((!dma_active && strm_start_pulse)
                                              || (dma_active && dma_header_int[q_sel].valid));
        default: start_pulse_next = 1'b0;
    endcase
end

always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        dma_active <= 1'b0;
        start_pulse_internal <= 1'b0;
        q_sel <= '0;
    end else if (clk_en) begin
        if (cfg_ld_dma_mode == OFF) begin
            dma_active <= 1'b0;
        end else if (strm_start_pulse) begin
            dma_active <= 1'b1;
        end
        start_pulse_internal <= start_pulse_internal ? 1'b0 : start_pulse_next;
        // auto-increment walks the queue one stream at a time
        if (cfg_ld_dma_mode != AUTO_INCR) begin
            q_sel <= '0;
        end else if (done_pulse_internal) begin
            q_sel <= q_sel + 1'b1;
        end
    end
end

// the start cycle already issues the first word straight from the queue
always_ff @(posedge clk) begin
    if (clk_en && start_pulse_internal) begin
        run_hdr <= dma_header_int[q_sel];
    end
end

always_comb begin
    cur_hdr = start_pulse_internal ? dma_header_int[q_sel] : run_hdr;
    issue = start_pulse_internal || (state == STRM_ACTIVE);
    active_left = start_pulse_internal ? cur_hdr.num_active_words : active_cnt;
end

// nested iterators with the inner level carrying into the outer one
always_comb begin
    carry = issue;
    last_word = 1'b1;
    for (int i = 0; i < LOOP_LEVEL; i++) begin
        itr_last[i] = (cur_hdr.iteration[i].range <= 1)
                      || (itr[i] == cur_hdr.iteration[i].range - 1'b1);
        itr_next[i] = itr[i];
        if (carry) begin
            itr_next[i] = itr_last[i] ? '0 : itr[i] + 1'b1;
        end
        carry = carry && itr_last[i];
        last_word = last_word && itr_last[i];
    end
    done_pulse_internal = issue && last_word;
end

// byte address with strides counted in 16-bit words
always_comb begin
    strm_addr = cur_hdr.start_addr;
    itr_ofs = '0;
    for (int i = 0; i < LOOP_LEVEL; i++) begin
        itr_ofs = glb_addr_t'(itr[i]) * glb_addr_t'(cur_hdr.iteration[i].stride);
        strm_addr = strm_addr + (itr_ofs << CGRA_LANE_LSB);
    end
end

// active/gap pattern
always_comb begin
    state_next = state;
    active_cnt_next = active_cnt;
    inactive_cnt_next = inactive_cnt;
    if (issue) begin
        if (done_pulse_internal) begin
            state_next = STRM_STOP;
        end else if ((active_left <= 1) && (cur_hdr.num_inactive_words != 0)) begin
            state_next = STRM_GAP;
            inactive_cnt_next = cur_hdr.num_inactive_words;
        end else begin
            state_next = STRM_ACTIVE;
            active_cnt_next = (active_left <= 1) ? cur_hdr.num_active_words
                                                 : active_left - 1'b1;
        end
    end else if (state == STRM_GAP) begin
        inactive_cnt_next = inactive_cnt - 1'b1;
        if (inactive_cnt <= 1) begin
            state_next = STRM_ACTIVE;
            active_cnt_next = cur_hdr.num_active_words;
        end
    end
end

always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        state <= STRM_STOP;
        active_cnt <= '0;
        inactive_cnt <= '0;
        strm_rdrq <= '0;
        for (int i = 0; i < LOOP_LEVEL; i++) begin
            itr[i] <= '0;
        end
    end else if (clk_en) begin
        state <= state_next;
        active_cnt <= active_cnt_next;
        inactive_cnt <= inactive_cnt_next;
        strm_rdrq.rd_en <= issue;
        if (issue) begin
            strm_rdrq.rd_addr <= strm_addr;
        end
        for (int i = 0; i < LOOP_LEVEL; i++) begin
            itr[i] <= itr_next[i];
        end
    end
end

glb_shift #(.DATA_WIDTH(1), .DEPTH(START_PULSE_SHIFT_DEPTH)) shift_start_i (
    .clk(clk), .clk_en(clk_en), .reset(reset),
    .data_in(start_pulse_internal), .data_out(start_pulse_d));

glb_shift #(.DATA_WIDTH(1), .DEPTH(FIXED_LATENCY)) shift_rd_en_i (
    .clk(clk), .clk_en(clk_en), .reset(reset),
    .data_in(strm_rdrq.rd_en), .data_out(rd_en_d));

glb_shift #(.DATA_WIDTH(GLB_ADDR_WIDTH), .DEPTH(FIXED_LATENCY)) shift_rd_addr_i (
    .clk(clk), .clk_en(clk_en), .reset(reset),
    .data_in(strm_rdrq.rd_addr), .data_out(rd_addr_d));

glb_shift #(.DATA_WIDTH(1), .DEPTH(FIXED_LATENCY+1)) shift_done_i (
    .clk(clk), .clk_en(clk_en), .reset(reset),
    .data_in(done_pulse_internal), .data_out(done_d));

// only go to the bank on the first word or a new row
assign row_same = (strm_rdrq.rd_addr[GLB_ADDR_WIDTH-1:BANK_ROW_LSB]
                   == rd_addr_d[0][GLB_ADDR_WIDTH-1:BANK_ROW_LSB]);
assign rdrq_packet.rd_en = strm_rdrq.rd_en && (start_pulse_d[0] || !row_same);
assign rdrq_packet.rd_addr = strm_rdrq.rd_addr;

always_ff @(posedge clk) begin
    if (clk_en && rdrs_packet.rd_data_valid) begin
        rdrs_cache <= rdrs_packet.rd_data;
    end
end

// lane picked with the address that travelled with the word
assign lane = rd_addr_d[FIXED_LATENCY-1][BANK_ROW_LSB-1:CGRA_LANE_LSB];
assign stream_data = rdrs_cache[lane*CGRA_DATA_WIDTH +: CGRA_DATA_WIDTH];
assign stream_data_valid = rd_en_d[FIXED_LATENCY-1];
assign stream_done_pulse = done_d[FIXED_LATENCY];

a_valid_has_req: assert property (@(posedge clk) disable iff (reset)
    $rose(stream_data_valid) |-> $past(strm_rdrq.rd_en, FIXED_LATENCY))
    else $error("stream word without a request %0d cycles earlier", FIXED_LATENCY);

endmodule

`default_nettype wire

// File: glb_ld_dma_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module glb_ld_dma_cfg import glb_param_pkg::*, glb_types_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cfg_wr_en,
    input  q_sel_t                 cfg_wr_sel,
    input  dma_ld_header_t         cfg_wr_header,
    input  logic                   invalidate_pulse [QUEUE_DEPTH],
    output dma_ld_header_t         cfg_ld_dma_header [QUEUE_DEPTH],
    output logic [QUEUE_DEPTH-1:0] queue_valid
);

// descriptor queue
// host write takes priority over a consume from the DMA
always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            cfg_ld_dma_header[i] <= '0;
        end
    end else begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (cfg_wr_en && (cfg_wr_sel == q_sel_t'(i))) begin
                cfg_ld_dma_header[i] <= cfg_wr_header;
            end else if (invalidate_pulse[i]) begin
                cfg_ld_dma_header[i].valid <= 1'b0;
            end
        end
    end
end

always_comb begin
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
        queue_valid[i] = cfg_ld_dma_header[i].valid;
    end
end

// DMA must only consume an entry that the host armed
for (genvar i = 0; i < QUEUE_DEPTH; i++) begin : g_inv_chk
    a_inv_valid: assert property (@(posedge clk) disable iff (reset)
        invalidate_pulse[i] |-> cfg_ld_dma_header[i].valid)
        else $error("invalidate pulse on empty queue entry %0d", i);
end

endmodule

`default_nettype wire

// File: glb_load.f
glb_param_pkg.sv
glb_types_pkg.sv
glb_shift.sv
glb_bank.sv
glb_ld_dma_cfg.sv
glb_core_load_dma.sv
glb_load_top.sv
tb_glb_load.sv

// File: glb_load_top.sv
`timescale 1ns/1ps
`default_nettype none

module glb_load_top import glb_param_pkg::*, glb_types_pkg::*; (
    input  logic                   clk,
    input  logic                   clk_en,
    input  logic                   reset,
    input  ld_dma_mode_e           cfg_ld_dma_mode,
    input  logic                   strm_start_pulse,
    output cgra_data_t             stream_data,
    output logic                   stream_data_valid,
    output logic                   stream_done_pulse,
    input  logic                   cfg_wr_en,
    input  q_sel_t                 cfg_wr_sel,
    input  dma_ld_header_t         cfg_wr_header,
    input  logic                   bank_wr_en,
    input  glb_addr_t              bank_wr_addr,
    input  bank_data_t             bank_wr_data,
    output logic [QUEUE_DEPTH-1:0] queue_valid
);

dma_ld_header_t cfg_ld_dma_header [QUEUE_DEPTH];
logic invalidate_pulse [QUEUE_DEPTH];
rdrq_packet_t rdrq_packet;
rdrs_packet_t rdrs_packet;

glb_ld_dma_cfg cfg_i (
    .clk(clk), .reset(reset),
    .cfg_wr_en(cfg_wr_en), .cfg_wr_sel(cfg_wr_sel), .cfg_wr_header(cfg_wr_header),
    .invalidate_pulse(invalidate_pulse), .cfg_ld_dma_header(cfg_ld_dma_header),
    .queue_valid(queue_valid));

glb_core_load_dma dma_i (
    .clk(clk), .clk_en(clk_en), .reset(reset),
    .cfg_ld_dma_mode(cfg_ld_dma_mode), .cfg_ld_dma_header(cfg_ld_dma_header),
    .strm_start_pulse(strm_start_pulse), .invalidate_pulse(invalidate_pulse),
    .rdrq_packet(rdrq_packet), .rdrs_packet(rdrs_packet),
    .stream_data(stream_data), .stream_data_valid(stream_data_valid),
    .stream_done_pulse(stream_done_pulse));

// bank runs off the raw clock
glb_bank bank_i (
    .clk(clk), .reset(reset),
    .wr_en(bank_wr_en), .wr_addr(bank_wr_addr), .wr_data(bank_wr_data),
    .rdrq_packet(rdrq_packet), .rdrs_packet(rdrs_packet));

endmodule

`default_nettype wire

// File: glb_param_pkg.sv
`default_nettype none

package glb_param_pkg;

// buffer address and data widths
localparam int GLB_ADDR_WIDTH = 12;
localparam int BANK_DATA_WIDTH = 64;
localparam int CGRA_DATA_WIDTH = 16;

// top byte index within a word and within a row
localparam int CGRA_BYTE_OFFSET = 1;
localparam int BANK_BYTE_OFFSET = 7;

// descriptor sizes
localparam int MAX_NUM_WORDS_WIDTH = 8;
localparam int LOOP_LEVEL = 2;
localparam int QUEUE_DEPTH = 2;

// pipeline latencies in cycles
localparam int BANK_RD_LATENCY = 3;
localparam int FIXED_LATENCY = 4;
localparam int START_PULSE_SHIFT_DEPTH = 2;

// derived address slicing
localparam int CGRA_LANE_LSB = $clog2(CGRA_BYTE_OFFSET + 1);
localparam int BANK_ROW_LSB = $clog2(BANK_BYTE_OFFSET + 1);
localparam int BANK_DEPTH = 2 ** (GLB_ADDR_WIDTH - BANK_ROW_LSB);

endpackage

`default_nettype wire

// File: glb_shift.sv
`timescale 1ns/1ps
`default_nettype none

module glb_shift #(
    parameter int DATA_WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  logic                  clk,
    input  logic                  clk_en,
    input  logic                  reset,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out [DEPTH]
);

// tap 0 lags data_in by one cycle, tap n by n+1
always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        for (int i = 0; i < DEPTH; i++) begin
            data_out[i] <= '0;
        end
    end else if (clk_en) begin
        data_out[0] <= data_in;
        for (int i = 1; i < DEPTH; i++) begin
            data_out[i] <= data_out[i-1];
        end
    end
end

endmodule

`default_nettype wire

// File: glb_types_pkg.sv
`default_nettype none

package glb_types_pkg;
import glb_param_pkg::*;

typedef logic [GLB_ADDR_WIDTH-1:0] glb_addr_t;
typedef logic [BANK_DATA_WIDTH-1:0] bank_data_t;
typedef logic [CGRA_DATA_WIDTH-1:0] cgra_data_t;
typedef logic [MAX_NUM_WORDS_WIDTH-1:0] num_words_t;
typedef logic [$clog2(QUEUE_DEPTH)-1:0] q_sel_t;

// one level of the strided walk
typedef struct packed {
    num_words_t range;
    num_words_t stride;
} loop_ctrl_t;

typedef struct packed {
    logic valid;
    glb_addr_t start_addr;
    num_words_t num_active_words;
    num_words_t num_inactive_words;
    loop_ctrl_t [LOOP_LEVEL-1:0] iteration;
} dma_ld_header_t;

// bank read request and response
typedef struct packed {
    logic rd_en;
    glb_addr_t rd_addr;
} rdrq_packet_t;

typedef struct packed {
    logic rd_data_valid;
    bank_data_t rd_data;
} rdrs_packet_t;

typedef enum logic [1:0] {OFF = 2'd0, NORMAL = 2'd1, REPEAT = 2'd2, AUTO_INCR = 2'd3} ld_dma_mode_e;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/bash
set -e
set -o pipefail

verilator --binary --timing --assert -Wno-fatal --top-module tb_glb_load -f glb_load.f
./obj_dir/Vtb_glb_load | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: tb_glb_load.sv
`timescale 1ns/1ps
`default_nettype none

module tb_glb_load import glb_param_pkg::*, glb_types_pkg::*; ();

localparam int WAIT_LIMIT = 400;

logic clk;
logic clk_en;
logic reset;
ld_dma_mode_e mode;
logic start;
cgra_data_t stream_data;
logic stream_data_valid;
logic stream_done_pulse;
logic cfg_wr_en;
q_sel_t cfg_wr_sel;
dma_ld_header_t cfg_wr_header;
logic bank_wr_en;
glb_addr_t bank_wr_addr;
bank_data_t bank_wr_data;
logic [QUEUE_DEPTH-1:0] queue_valid;

bank_data_t mem_model [BANK_DEPTH];
cgra_data_t exp_q [$];
cgra_data_t got_q [$];
cgra_data_t first_run [$];
logic [31:0] rand_state;
int errors;
int checks;
dma_ld_header_t hdr_a;
dma_ld_header_t hdr_b;

glb_load_top dut_i (
    .clk(clk), .clk_en(clk_en), .reset(reset),
    .cfg_ld_dma_mode(mode), .strm_start_pulse(start),
    .stream_data(stream_data), .stream_data_valid(stream_data_valid),
    .stream_done_pulse(stream_done_pulse),
    .cfg_wr_en(cfg_wr_en), .cfg_wr_sel(cfg_wr_sel), .cfg_wr_header(cfg_wr_header),
    .bank_wr_en(bank_wr_en), .bank_wr_addr(bank_wr_addr), .bank_wr_data(bank_wr_data),
    .queue_valid(queue_valid));

initial begin
    clk = 1'b0;
    forever begin
        #2 clk = ~clk;
    end
end

// halves swapped so the weak low bits of the LCG end up on top
function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return {rand_state[15:0], rand_state[31:16]};
endfunction

task automatic check_word(input string name, input cgra_data_t got, input cgra_data_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_count(input string name, input num_words_t got, input num_words_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_queue(input string name, input logic [QUEUE_DEPTH-1:0] got,
                           input logic [QUEUE_DEPTH-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic abort_run(input string why);
    errors++;
    $display("run stopped at %0t ns: %s", $time, why);
    $display("errors: %0d, checks: %0d", errors, checks);
    $display("=== FAIL ===");
    $finish;
endtask

task automatic fill_bank();
    bank_data_t row;
    for (int r = 0; r < BANK_DEPTH; r++) begin
        row = {next_rand(), next_rand()};
        mem_model[r] = row;
        @(negedge clk);
        bank_wr_en = 1'b1;
        bank_wr_addr = glb_addr_t'(r << BANK_ROW_LSB);
        bank_wr_data = row;
    end
    @(negedge clk);
    bank_wr_en = 1'b0;
endtask

// inner loop range 3..6 keeps every stream at six words or more
task automatic make_header(input logic with_gaps, output dma_ld_header_t h);
    h = '0;
    h.valid = 1'b1;
    h.start_addr = glb_addr_t'(next_rand() << 1);
    h.iteration[0].range = num_words_t'(3 + next_rand() % 4);
    h.iteration[0].stride = num_words_t'(next_rand() % 12);
    h.iteration[1].range = num_words_t'(2 + next_rand() % 3);
    h.iteration[1].stride = num_words_t'(next_rand() % 40);
    h.num_active_words = with_gaps ? num_words_t'(1 + next_rand() % 4) : num_words_t'(1);
    h.num_inactive_words = with_gaps ? num_words_t'(1 + next_rand() % 3) : num_words_t'(0);
endtask

// reference model walks both loops inner level first and picks the lane
function automatic void build_expected(input dma_ld_header_t h);
    int r0;
    int r1;
    glb_addr_t a;
    exp_q.delete();
    r0 = (h.iteration[0].range == 0) ? 1 : int'(h.iteration[0].range);
    r1 = (h.iteration[1].range == 0) ? 1 : int'(h.iteration[1].range);
    for (int j1 = 0; j1 < r1; j1++) begin
        for (int j0 = 0; j0 < r0; j0++) begin
            a = glb_addr_t'(h.start_addr + 2 * (j0 * h.iteration[0].stride
                                                + j1 * h.iteration[1].stride));
            exp_q.push_back(mem_model[a[GLB_ADDR_WIDTH-1:BANK_ROW_LSB]]
                            [a[BANK_ROW_LSB-1:CGRA_LANE_LSB] * CGRA_DATA_WIDTH +: CGRA_DATA_WIDTH]);
        end
    end
endfunction

task automatic write_header(input q_sel_t sel, input dma_ld_header_t h);
    @(negedge clk);
    cfg_wr_en = 1'b1;
    cfg_wr_sel = sel;
    cfg_wr_header = h;
    @(negedge clk);
    cfg_wr_en = 1'b0;
endtask

task automatic pulse_start();
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
endtask

task automatic idle_cycles(input int n);
    repeat (n) begin
        @(negedge clk);
        if (stream_data_valid || stream_done_pulse) begin
            errors++;
            $display("unexpected stream activity at %0t ns", $time);
        end
    end
endtask

// cycle count starts at 1 on the falling edge that drops the start pulse
task automatic collect_stream(input dma_ld_header_t h, input logic check_lat,
                              input logic [QUEUE_DEPTH-1:0] exp_queue);
    int cyc;
    int idx;
    int gap;
    int act;
    logic done_seen;
    cyc = 1;
    idx = 0;
    gap = 0;
    done_seen = 1'b0;
    act = (h.num_active_words == 0) ? 1 : int'(h.num_active_words);
    got_q.delete();
    while (!done_seen && cyc < WAIT_LIMIT) begin
        @(negedge clk);
        cyc++;
        if (stream_data_valid) begin
            if (idx == 0) begin
                if (check_lat) begin
                    check_count("first word latency", num_words_t'(cyc), num_words_t'(6));
                end
                check_queue("queue_valid", queue_valid, exp_queue);
            end else if (idx % act == 0) begin
                check_count("idle gap", num_words_t'(gap), h.num_inactive_words);
            end else begin
                check_count("idle gap", num_words_t'(gap), num_words_t'(0));
            end
            if (idx < exp_q.size()) begin
                check_word("stream_data", stream_data, exp_q[idx]);
            end else begin
                errors++;
                $display("stream longer than expected at %0t ns", $time);
            end
            got_q.push_back(stream_data);
            idx++;
            gap = 0;
        end else begin
            gap++;
        end
        if (stream_done_pulse) begin
            done_seen = 1'b1;
            if (!stream_data_valid) begin
                errors++;
                $display("done pulse came without a valid word at %0t ns", $time);
            end
        end
    end
    if (!done_seen) begin
        abort_run("stream never raised its done pulse");
    end else begin
        check_count("words in stream", num_words_t'(idx), num_words_t'(exp_q.size()));
    end
endtask

initial begin
    rand_state = 32'h9cf8;
    errors = 0;
    checks = 0;
    clk_en = 1'b1;
    reset = 1'b1;
    mode = OFF;
    start = 1'b0;
    cfg_wr_en = 1'b0;
    cfg_wr_sel = '0;
    cfg_wr_header = '0;
    bank_wr_en = 1'b0;
    bank_wr_addr = '0;
    bank_wr_data = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_queue("queue_valid after reset", queue_valid, 2'b00);
    idle_cycles(4);
    fill_bank();

    // plain strided walk, row reuse and row crossings
    mode = NORMAL;
    make_header(1'b0, hdr_a);
    write_header(0, hdr_a);
    idle_cycles(3);
    build_expected(hdr_a);
    pulse_start();
    collect_stream(hdr_a, 1'b1, 2'b00);
    idle_cycles(8);

    // active/idle pattern with the DMA frozen for a while before each start
    repeat (3) begin
        make_header(1'b1, hdr_a);
        write_header(0, hdr_a);
        clk_en = 1'b0;
        repeat (3) @(negedge clk);
        clk_en = 1'b1;
        idle_cycles(3);
        build_expected(hdr_a);
        pulse_start();
        collect_stream(hdr_a, 1'b1, 2'b00);
        idle_cycles(8);
    end

    // OFF ignores start pulses and leaves the queue alone
    mode = OFF;
    make_header(1'b0, hdr_a);
    write_header(0, hdr_a);
    idle_cycles(3);
    pulse_start();
    pulse_start();
    idle_cycles(12);
    check_queue("queue_valid in OFF mode", queue_valid, 2'b01);

    // one pulse runs entry 0, then entry 1
    make_header(1'b1, hdr_b);
    write_header(1, hdr_b);
    idle_cycles(3);
    mode = AUTO_INCR;
    build_expected(hdr_a);
    pulse_start();
    collect_stream(hdr_a, 1'b1, 2'b10);
    build_expected(hdr_b);
    collect_stream(hdr_b, 1'b0, 2'b00);
    idle_cycles(10);
    check_queue("queue_valid after auto-increment", queue_valid, 2'b00);

    // re-arming entry 0 restarts it without a pulse
    mode = OFF;
    idle_cycles(2);
    mode = REPEAT;
    make_header(1'b1, hdr_a);
    write_header(0, hdr_a);
    idle_cycles(3);
    build_expected(hdr_a);
    pulse_start();
    collect_stream(hdr_a, 1'b1, 2'b00);
    first_run = got_q;
    idle_cycles(6);
    write_header(0, hdr_a);
    collect_stream(hdr_a, 1'b0, 2'b00);
    check_count("repeat length", num_words_t'(got_q.size()), num_words_t'(first_run.size()));
    for (int i = 0; i < first_run.size() && i < got_q.size(); i++) begin
        check_word("repeated stream_data", got_q[i], first_run[i]);
    end
    idle_cycles(10);

    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
        $display("=== PASS ===");
    end else begin
        $display("=== FAIL ===");
    end
    $finish;
end

endmodule

`default_nettype wire
